//--- sim/neoIoTb.sv
`default_nettype none
`include "neoIoCfg.svh"

module neoIoTb;

	timeunit 1ns;
	timeprecision 100ps;

	import neoIoPkg::*;

	// Accesses of tests 2 to 6, about four cycles each
	localparam int accessCount = 170;
	localparam int cycleLimit = accessCount * 4 + 16 + 256;

	logic                  clk24M;
	logic                  reset;
	busReq_t               req;
	logic                  reqValid;
	logic                  reqReady;
	busRsp_t               rsp;
	logic                  rspValid;
	logic                  rspReady;
	logic [9:0]            p1In;
	logic [9:0]            p2In;
	logic [7:0]            dipSw;
	logic                  testBtn;
	logic [1:0]            coinIn;
	logic [7:0]            soundReply;
	logic                  rtcTp;
	logic                  rtcData;
	logic [1:0]            cardDetect;
	logic                  cardProtect;
	logic [2:0]            p1Out;
	logic [2:0]            p2Out;
	logic [2:0]            cardBank;
	logic [2:0]            slotSel;
	logic [2:0]            elOut;
	logic [7:0]            led1Out;
	logic [7:0]            led2Out;
	logic [2:0]            rtcCtrl;
	logic [7:0]            soundCmd;
	logic [1:0]            counters;
	logic [1:0]            lockouts;
	sysLatch_t             sysLatch;

	// Shadow of the write side, all zero out of reset
	logic [2:0]            expP1Out = '0;
	logic [2:0]            expP2Out = '0;
	logic [2:0]            expCardBank = '0;
	logic [2:0]            expSlotSel = '0;
	logic [2:0]            expElOut = '0;
	logic [7:0]            expLed1 = '0;
	logic [7:0]            expLed2 = '0;
	logic [2:0]            expRtcCtrl = '0;
	logic [7:0]            expSoundCmd = '0;
	logic [2:0]            expLedLatch = '0;
	logic [7:0]            expLedData = '0;
	logic [1:0]            expCounters = '0;
	logic [1:0]            expLockouts = '0;
	sysLatch_t             expSysLatch = '0;

	// Expected bytes of accepted accesses, oldest first
	busRsp_t               expQ[$];
	logic [15:0]           lfsr = 16'd52;
	int                    checkCount = 0;
	int                    errorCount = 0;
	int                    cycleCount = 0;

	tbClock clockGen (.clk(clk24M));

	neoIoTop DUT (.*);

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
		end
		return value;
	endfunction

	// Reads 0 to 13, writes 14 to 23
	function automatic logic [`IO_ADDR_W-1:0] accessTarget(input int i);
		case (i)
			0: return 24'h300000;
			1: return 24'h300001;
			2: return 24'h300081;
			3: return 24'h320000;
			4: return 24'h320001;
			5: return 24'h340000;
			6: return 24'h360001;
			7: return 24'h380000;
			8: return 24'h380001;
			9: return 24'h3A0001;
			10: return 24'h3A0000;
			11: return 24'h3C0000;
			12: return 24'h3E0001;
			13: return 24'h100001;
			14: return 24'h380001;
			15: return 24'h380011;
			16: return 24'h380021;
			17: return 24'h380051;
			// High bank copy of the RTC register
			18: return 24'h3800D1;
			19: return 24'h320000;
			20: return 24'h3C0000;
			21: return 24'h200001;
			22: return 24'h3A0000;
			default: return 24'h300000;
		endcase
	endfunction

	// Expected read byte from the board map by address range
	function automatic busRsp_t expectedRead(input logic [`IO_ADDR_W-1:0] addr, input logic write);
		busRsp_t b;
		b.data = `OPEN_BUS;
		if (!write) begin
			if (addr >= 24'h300000 && addr < 24'h320000) begin
				if (!addr[0]) b.data = p1In[7:0];
				else if (addr[7]) b.data = {testBtn, 7'h7F};
				else b.data = dipSw;
			end else if (addr >= 24'h320000 && addr < 24'h340000) begin
				if (!addr[0]) b.data = soundReply;
				else b.data = {rtcData, rtcTp, 4'hF, coinIn};
			end else if (addr >= 24'h340000 && addr < 24'h380000) begin
				b.data = p2In[7:0];
			end else if (addr >= 24'h380000 && addr < 24'h3A0000 && !addr[0]) begin
				// MVS flag on top
				b.data = {1'b1, cardProtect, cardDetect, p2In[9:8], p1In[9:8]};
			end
		end
		return b;
	endfunction

	// Write side of the shadow model
	task automatic modelWrite(input logic [`IO_ADDR_W-1:0] addr, input logic [7:0] data);
		if (addr >= 24'h320000 && addr < 24'h340000 && !addr[0]) expSoundCmd = data;
		if (addr >= 24'h3A0000 && addr < 24'h3C0000 && addr[0]) expSysLatch[addr[3:1]] = addr[4];
		if (addr >= 24'h380000 && addr < 24'h3A0000 && addr[0]) begin
			case (addr[6:4])
				3'd0: {expP2Out, expP1Out} = data[5:0];
				3'd1: expCardBank = data[2:0];
				3'd2: expSlotSel = data[2:0];
				3'd3: begin
					// Copy on a latch bit going low
					if (expLedLatch[0] && !data[3]) expElOut = expLedData[2:0];
					if (expLedLatch[1] && !data[4]) expLed1 = expLedData;
					if (expLedLatch[2] && !data[5]) expLed2 = expLedData;
					expLedLatch = data[5:3];
				end
				3'd4: expLedData = data;
				3'd5: if (!addr[7]) expRtcCtrl = data[2:0];
				default: begin
					// Counter commands, A4 new state, A2 picks lockouts
					if (!addr[2]) expCounters[addr[1]] = addr[4];
					else expLockouts[addr[1]] = addr[4];
				end
			endcase
		end
	endtask

	task automatic randomizeInputs();
		p1In = 10'(randBits(10));
		p2In = 10'(randBits(10));
		dipSw = 8'(randBits(8));
		soundReply = 8'(randBits(8));
		{cardProtect, cardDetect, rtcData, rtcTp, coinIn, testBtn} = 8'(randBits(8));
	endtask

	task automatic checkRsp(input busRsp_t got, input busRsp_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error: rsp.data got %h expected %h", got.data, exp.data);
		end
	endtask

	task automatic checkLatch(input sysLatch_t got, input sysLatch_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error: sysLatch got %h expected %h", got, exp);
		end
	endtask

	task automatic checkVec(input string name, input logic [7:0] got, input logic [7:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCount++;
		if (cond !== 1'b1) begin
			errorCount++;
			$display("Failure: %s", what);
		end
	endtask

	// All write-side ports against the shadow, between edges
	task automatic checkOutputs();
		@(negedge clk24M);
		checkVec("p1Out", p1Out, expP1Out);
		checkVec("p2Out", p2Out, expP2Out);
		checkVec("cardBank", cardBank, expCardBank);
		checkVec("slotSel", slotSel, expSlotSel);
		checkVec("elOut", elOut, expElOut);
		checkVec("led1Out", led1Out, expLed1);
		checkVec("led2Out", led2Out, expLed2);
		checkVec("rtcCtrl", rtcCtrl, expRtcCtrl);
		checkVec("soundCmd", soundCmd, expSoundCmd);
		checkVec("counters", counters, expCounters);
		checkVec("lockouts", lockouts, expLockouts);
		checkLatch(sysLatch, expSysLatch);
	endtask

	// Holds the request until an edge with reqReady high
	task automatic waitAccept();
		do begin
			@(posedge clk24M);
		end while (reqReady !== 1'b1);
		expQ.push_back(expectedRead(req.addr, req.write));
		if (req.write) modelWrite(req.addr, req.data);
	endtask

	// Queue looked at between edges, after the checker has popped
	task automatic waitDrain();
		while (expQ.size() != 0) @(negedge clk24M);
	endtask

	task automatic busAccess(input logic [`IO_ADDR_W-1:0] addr, input logic write,
			input logic [7:0] data);
		@(negedge clk24M);
		req.addr = addr;
		req.write = write;
		req.data = data;
		reqValid = 1'b1;
		waitAccept();
		@(negedge clk24M);
		reqValid = 1'b0;
		// One cycle of latency
		checkTrue(rspValid === 1'b1, "no response one cycle after acceptance");
		waitDrain();
	endtask

	task automatic endTest(input int num, input string name, input int errStart);
		$display("Test %0d %s finished with %0d errors", num, name, errorCount - errStart);
	endtask

	// Response checker, pops on each completed handshake
	always @(posedge clk24M) begin
		if (!reset && rspValid && rspReady) begin
			if (expQ.size() == 0) begin
				errorCount++;
				$display("Failure: response with no access pending");
			end else begin
				checkRsp(rsp, expQ.pop_front());
			end
		end
	end

	always @(posedge clk24M) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run passed %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int          errStart;
		logic [15:0] r;
		busRsp_t     held;
		reset = 1'b1;
		req = '0;
		reqValid = 1'b0;
		rspReady = 1'b1;
		randomizeInputs();
		repeat (16) @(posedge clk24M);
		@(negedge clk24M);
		reset = 1'b0;

		errStart = errorCount;
		checkOutputs();
		checkTrue(rspValid === 1'b0, "rspValid high after reset");
		endTest(1, "reset state", errStart);

		// Don't-care address bits randomized too
		errStart = errorCount;
		for (int round = 0; round < 4; round++) begin
			for (int i = 0; i < 14; i++) begin
				@(negedge clk24M);
				randomizeInputs();
				r = randBits(15);
				busAccess(accessTarget(i) | {7'd0, r[14:6], 1'b0, r[5:0], 1'b0}, 1'b0, 8'h00);
			end
		end
		endTest(2, "read zones", errStart);

		errStart = errorCount;
		for (int round = 0; round < 4; round++) begin
			for (int i = 14; i < 24; i++) begin
				busAccess(accessTarget(i), 1'b1, 8'(randBits(8)));
				checkOutputs();
			end
		end
		endTest(3, "output registers", errStart);

		// Data register then latch register
		errStart = errorCount;
		for (int i = 0; i < 12; i++) begin
			busAccess(24'h380041, 1'b1, 8'(randBits(8)));
			checkOutputs();
			busAccess(24'h380031, 1'b1, 8'(randBits(8)));
			checkOutputs();
		end
		endTest(4, "LED transfer", errStart);

		// Set all four targets, clear them, then random commands
		errStart = errorCount;
		for (int i = 0; i < 8; i++) begin
			busAccess(24'h380061 | {19'd0, !i[2], 1'b0, i[1:0], 1'b0}, 1'b1, 8'(randBits(8)));
			checkOutputs();
		end
		for (int i = 0; i < 16; i++) begin
			r = randBits(5);
			busAccess(24'h380061 | {16'd0, r[4], 2'b00, r[3:0], 1'b0}, 1'b1, 8'(randBits(8)));
			checkOutputs();
		end
		endTest(5, "coin counters", errStart);

		errStart = errorCount;
		for (int i = 0; i < 16; i++) begin
			busAccess(24'h3A0001 | {19'd0, !i[3], i[2:0], 1'b0}, 1'b1, 8'(randBits(8)));
			checkOutputs();
		end
		for (int i = 0; i < 8; i++) begin
			r = randBits(4);
			busAccess(24'h3A0001 | {19'd0, r[3:0], 1'b0}, 1'b1, 8'h00);
			checkOutputs();
		end
		// Back-pressure, second request waits behind a held byte
		@(negedge clk24M);
		rspReady = 1'b0;
		req.addr = 24'h300000;
		req.write = 1'b0;
		reqValid = 1'b1;
		waitAccept();
		@(negedge clk24M);
		req.addr = 24'h380000;
		held = rsp;
		for (int i = 0; i < 6; i++) begin
			@(negedge clk24M);
			p1In = 10'(randBits(10));
			checkRsp(rsp, held);
			checkTrue(rspValid === 1'b1 && reqReady === 1'b0,
				"request accepted or response lost while rspReady was low");
		end
		rspReady = 1'b1;
		waitAccept();
		@(negedge clk24M);
		reqValid = 1'b0;
		waitDrain();
		endTest(6, "system latch and back-pressure", errStart);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`default_nettype none

module tbClock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period, starts low
	initial clk = 1'b0;
	always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- source/coinCounters.sv
`default_nettype none

module coinCounters (
	input  wire                        clk24M,
	input  wire                        reset,
	input  wire neoIoPkg::ioAccess_t   access,
	input  wire                        accessValid,
	output logic [1:0]                 counters,
	output logic [1:0]                 lockouts
);

	import neoIoPkg::*;

	logic cmdWrite;

	// Command in the address only, data byte ignored
	assign cmdWrite = accessValid && access.write && access.zone == zoneBitW0
		&& access.offset.cntView.marker == 2'b11;

	always_ff @(posedge clk24M) begin
		if (reset) begin
			counters <= 2'b00;
			lockouts <= 2'b00;
		end else if (cmdWrite) begin
			// A2..A1 picks the target, A4 set or clear
			case (access.offset.cntView.index[1:0])
				2'd0: counters[0] <= access.offset.cntView.setBit;
				2'd1: counters[1] <= access.offset.cntView.setBit;
				2'd2: lockouts[0] <= access.offset.cntView.setBit;
				2'd3: lockouts[1] <= access.offset.cntView.setBit;
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/inputPorts.sv
`default_nettype none
`include "neoIoCfg.svh"

module inputPorts (
	input  wire neoIoPkg::ioAccess_t   access,
	input  wire [9:0]                  p1In,
	input  wire [9:0]                  p2In,
	input  wire [7:0]                  dipSw,
	input  wire                        testBtn,
	input  wire [1:0]                  coinIn,
	input  wire [7:0]                  soundReply,
	input  wire                        rtcTp,
	input  wire                        rtcData,
	input  wire [1:0]                  cardDetect,
	input  wire                        cardProtect,
	output logic [`IO_DATA_W-1:0]      readData
);

	import neoIoPkg::*;

	// Combinational read mux, sampled by the decoder on acceptance
	always_comb begin
		readData = `OPEN_BUS;
		case (access.zone)
			// Stick and buttons A..D
			zoneP1Cnt: readData = p1In[7:0];
			zoneP2Cnt: readData = p2In[7:0];
			zoneDipSw: readData = dipSw;
			// Test button alone in bit 7
			zoneTest: begin
				readData = `OPEN_BUS;
				readData[7] = testBtn;
			end
			// Reply byte from the sound CPU
			zoneSound: readData = soundReply;
			// Coins low, RTC pins high
			zoneStatusA: begin
				readData = `OPEN_BUS;
				readData[1:0] = coinIn;
				readData[6] = rtcTp;
				readData[7] = rtcData;
			end
			// Start and select pairs, card pins, MVS flag
			zoneStatusB: begin
				readData[1:0] = p1In[9:8];
				readData[3:2] = p2In[9:8];
				readData[5:4] = cardDetect;
				readData[6] = cardProtect;
				readData[7] = 1'b1;
			end
			// Write-only and unmapped zones float
			default: readData = `OPEN_BUS;
		endcase
	end

endmodule

`default_nettype wire

//--- source/ioDecode.sv
`default_nettype none
`include "neoIoCfg.svh"

module ioDecode (
	input  wire                        clk24M,
	input  wire                        reset,
	input  wire neoIoPkg::busReq_t     req,
	input  wire                        reqValid,
	output logic                       reqReady,
	output neoIoPkg::busRsp_t          rsp,
	output logic                       rspValid,
	input  wire                        rspReady,
	output neoIoPkg::ioAccess_t        access,
	output logic                       accessValid,
	input  wire [`IO_DATA_W-1:0]       readData
);

	import neoIoPkg::*;

	logic accept;

	// Zone from A23..A17, A7 and A0
	function automatic ioZone_t decodeZone(input logic [`IO_ADDR_W-1:0] addr);
		ioZone_t zone;
		zone = zoneNone;
		if (addr[`IO_ADDR_W-1 -: 4] == `IO_REGION) begin
			case (addr[19:17])
				// P1 on even, DIP or test button on odd
				3'b000: begin
					if (!addr[0]) begin
						zone = zoneP1Cnt;
					end else if (addr[7]) begin
						zone = zoneTest;
					end else begin
						zone = zoneDipSw;
					end
				end
				3'b001: zone = addr[0] ? zoneStatusA : zoneSound;
				// A17 not decoded for P2
				3'b010,
				3'b011: zone = zoneP2Cnt;
				3'b100: zone = addr[0] ? zoneBitW0 : zoneStatusB;
				3'b101: zone = addr[0] ? zoneBitW1 : zoneNone;
				// Video chip zone and the rest stay open
				default: zone = zoneNone;
			endcase
		end
		return zone;
	endfunction

	// Free when nothing pending or the pending byte leaves now
	assign reqReady = !rspValid || rspReady;
	assign accept = reqValid && reqReady;
	assign accessValid = accept;

	always_comb begin
		access.zone = decodeZone(req.addr);
		access.offset = req.addr[7:0];
		access.write = req.write;
		access.data = req.data;
	end

	always_ff @(posedge clk24M) begin
		if (reset) begin
			rspValid <= 1'b0;
		end else if (accept) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	// Byte held until it is taken
	always_ff @(posedge clk24M) begin
		if (accept) begin
			if (req.write || access.zone == zoneNone) begin
				rsp.data <= `OPEN_BUS;
			end else begin
				rsp.data <= readData;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/neoIoCfg.svh
`ifndef NEO_IO_CFG_SVH
`define NEO_IO_CFG_SVH

// 68000 byte address, A23 down to A0
`define IO_ADDR_W 24

// One data byte on the low lane
`define IO_DATA_W 8

// A23..A20 pattern of the I/O region
`define IO_REGION 4'h3

// Pull-ups on the data bus when nothing drives it
`define OPEN_BUS 8'hFF

`endif

//--- source/neoIoPkg.sv
`default_nettype none
`include "neoIoCfg.svh"

package neoIoPkg;

	// One CPU access as seen at the bus port
	typedef struct packed {
		logic [`IO_ADDR_W-1:0] addr;
		logic                  write;
		logic [`IO_DATA_W-1:0] data;
	} busReq_t;

	// Read byte, open bus for writes
	typedef struct packed {
		logic [`IO_DATA_W-1:0] data;
	} busRsp_t;

	// Decoded register zones
	typedef enum logic [3:0] {
		zoneNone,
		zoneP1Cnt,
		zoneDipSw,
		zoneTest,
		zoneSound,
		zoneStatusA,
		zoneP2Cnt,
		zoneStatusB,
		zoneBitW0,
		zoneBitW1
	} ioZone_t;

	// Low address byte, bit-write register view
	typedef struct packed {
		logic       highBank;
		logic [2:0] regSel;
		logic [3:0] lowBits;
	} ioRegView_t;

	// Low address byte, counter and system latch view
	typedef struct packed {
		logic       a7;
		logic [1:0] marker;
		logic       setBit;
		logic [2:0] index;
		logic       a0;
	} ioCntView_t;

	typedef union packed {
		ioRegView_t regView;
		ioCntView_t cntView;
	} ioOffset_u;

	// Access handed to the register blocks in its acceptance cycle
	typedef struct packed {
		ioZone_t               zone;
		ioOffset_u             offset;
		logic                  write;
		logic [`IO_DATA_W-1:0] data;
	} ioAccess_t;

	// System latch, bit 0 is index 0
	typedef struct packed {
		logic palBank;
		logic sramLock;
		logic sysFix;
		logic cardRegEn;
		logic cardWenB;
		logic cardWen;
		logic vecSwap;
		logic shadow;
	} sysLatch_t;

endpackage

`default_nettype wire

//--- source/neoIoTop.sv
`default_nettype none
`include "neoIoCfg.svh"

module neoIoTop (
	input  wire                        clk24M,
	input  wire                        reset,
	input  wire neoIoPkg::busReq_t     req,
	input  wire                        reqValid,
	output logic                       reqReady,
	output neoIoPkg::busRsp_t          rsp,
	output logic                       rspValid,
	input  wire                        rspReady,
	input  wire [9:0]                  p1In,
	input  wire [9:0]                  p2In,
	input  wire [7:0]                  dipSw,
	input  wire                        testBtn,
	input  wire [1:0]                  coinIn,
	input  wire [7:0]                  soundReply,
	input  wire                        rtcTp,
	input  wire                        rtcData,
	input  wire [1:0]                  cardDetect,
	input  wire                        cardProtect,
	output logic [2:0]                 p1Out,
	output logic [2:0]                 p2Out,
	output logic [2:0]                 cardBank,
	output logic [2:0]                 slotSel,
	output logic [2:0]                 elOut,
	output logic [7:0]                 led1Out,
	output logic [7:0]                 led2Out,
	output logic [2:0]                 rtcCtrl,
	output logic [7:0]                 soundCmd,
	output logic [1:0]                 counters,
	output logic [1:0]                 lockouts,
	output neoIoPkg::sysLatch_t        sysLatch
);

	import neoIoPkg::*;

	ioAccess_t             access;
	logic                  accessValid;
	logic [`IO_DATA_W-1:0] readData;

	// Bus port and zone decode
	ioDecode decode (
		.clk24M, .reset, .req, .reqValid, .reqReady, .rsp, .rspValid, .rspReady,
		.access, .accessValid, .readData
	);

	// Read side
	inputPorts ports (
		.access, .p1In, .p2In, .dipSw, .testBtn, .coinIn, .soundReply,
		.rtcTp, .rtcData, .cardDetect, .cardProtect, .readData
	);

	// Bit-write registers and sound command
	outputLatches latches (
		.clk24M, .reset, .access, .accessValid, .p1Out, .p2Out, .cardBank,
		.slotSel, .elOut, .led1Out, .led2Out, .rtcCtrl, .soundCmd
	);

	// Coin counters and lockouts
	coinCounters coins (
		.clk24M, .reset, .access, .accessValid, .counters, .lockouts
	);

	systemLatch sysCtrl (
		.clk24M, .reset, .access, .accessValid, .sysLatch
	);

endmodule

`default_nettype wire

//--- source/outputLatches.sv
`default_nettype none

module outputLatches (
	input  wire                        clk24M,
	input  wire                        reset,
	input  wire neoIoPkg::ioAccess_t   access,
	input  wire                        accessValid,
	output logic [2:0]                 p1Out,
	output logic [2:0]                 p2Out,
	output logic [2:0]                 cardBank,
	output logic [2:0]                 slotSel,
	output logic [2:0]                 elOut,
	output logic [7:0]                 led1Out,
	output logic [7:0]                 led2Out,
	output logic [2:0]                 rtcCtrl,
	output logic [7:0]                 soundCmd
);

	import neoIoPkg::*;

	logic       bitWrite;
	logic       soundWrite;
	logic [2:0] ledLatch;
	logic [7:0] ledData;
	logic [2:0] ledFall;

	// Bit-write zone, counter commands excluded by the select range
	assign bitWrite = accessValid && access.write && access.zone == zoneBitW0;
	assign soundWrite = accessValid && access.write && access.zone == zoneSound;

	// Latch bits 5..3 dropping from 1 to 0 in this write
	assign ledFall = ledLatch & ~access.data[5:3];

	always_ff @(posedge clk24M) begin
		if (reset) begin
			p1Out <= 3'b000;
			p2Out <= 3'b000;
			cardBank <= 3'b000;
			slotSel <= 3'b000;
			ledLatch <= 3'b000;
			ledData <= 8'h00;
			elOut <= 3'b000;
			led1Out <= 8'h00;
			led2Out <= 8'h00;
			rtcCtrl <= 3'b000;
		end else if (bitWrite) begin
			case (access.offset.regView.regSel)
				// Player outputs share one byte
				3'd0: begin
					p1Out <= access.data[2:0];
					p2Out <= access.data[5:3];
				end
				3'd1: cardBank <= access.data[2:0];
				3'd2: slotSel <= access.data[2:0];
				// Falling latch bit moves the data to its display
				3'd3: begin
					ledLatch <= access.data[5:3];
					if (ledFall[0]) begin
						elOut <= ledData[2:0];
					end
					if (ledFall[1]) begin
						led1Out <= ledData;
					end
					if (ledFall[2]) begin
						led2Out <= ledData;
					end
				end
				3'd4: ledData <= access.data;
				// RTC pins only in the low bank
				3'd5: begin
					if (!access.offset.regView.highBank) begin
						rtcCtrl <= access.data[2:0];
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Command byte to the sound CPU
	always_ff @(posedge clk24M) begin
		if (reset) begin
			soundCmd <= 8'h00;
		end else if (soundWrite) begin
			soundCmd <= access.data;
		end
	end

endmodule

`default_nettype wire

//--- source/systemLatch.sv
`default_nettype none

module systemLatch (
	input  wire                        clk24M,
	input  wire                        reset,
	input  wire neoIoPkg::ioAccess_t   access,
	input  wire                        accessValid,
	output neoIoPkg::sysLatch_t        sysLatch
);

	import neoIoPkg::*;

	logic latchWrite;

	// Any write in the odd half of the bit-write 1 zone
	assign latchWrite = accessValid && access.write && access.zone == zoneBitW1;

	// Addressable latch, A3..A1 index, A4 value
	always_ff @(posedge clk24M) begin
		if (reset) begin
			sysLatch <= '0;
		end else if (latchWrite) begin
			sysLatch[access.offset.cntView.index] <= access.offset.cntView.setBit;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/neoIoPkg.sv
source/ioDecode.sv
source/inputPorts.sv
source/outputLatches.sv
source/coinCounters.sv
source/systemLatch.sv
source/neoIoTop.sv
sim/tbClock.sv
sim/neoIoTb.sv
